// File: common/gen_params.svh
`ifndef GEN_PARAMS_SVH
`define GEN_PARAMS_SVH

// ----------------------------------------
// Register map
// ----------------------------------------
`define GEN_ADDR_NUMPKTS   8'h00   // Frames per batch
`define GEN_ADDR_START     8'h03   // Bit 0 launches a batch
`define GEN_ADDR_STOP      8'h04   // Bit 0 ends batch after current frame
`define GEN_ADDR_MACSA0    8'h05   // Source MAC [31:0]
`define GEN_ADDR_MACSA1    8'h06   // Source MAC [47:32]
`define GEN_ADDR_MACDA0    8'h07   // Destination MAC [31:0]
`define GEN_ADDR_MACDA1    8'h08   // Destination MAC [47:32]
`define GEN_ADDR_TXPKTCNT  8'h09   // Frames sent, read only
`define GEN_ADDR_PKTLENGTH 8'h0d   // Frame length in bytes

// Bus widths
`define GEN_DATA_W 64
`define GEN_CSR_W  32
`define GEN_ADDR_W 8

// ----------------------------------------
// Length handling
// ----------------------------------------
`define GEN_HDR_BYTES     24     // Taken off pkt_length to get payload bytes
`define GEN_MAX_PAYLOAD   9576   // Payload clamp
`define GEN_LEN_FIELD_ADJ 6      // Added to payload length for the length field

// Incrementing byte payload, one lane per byte
`define GEN_PATTERN_INIT 64'h0001020304050607
`define GEN_PATTERN_STEP 64'h0808080808080808

`endif

// File: common/gen_pkg.sv
`include "gen_params.svh"

package gen_pkg;

   // Settings held by the register bank
   typedef struct packed {
      logic [`GEN_CSR_W-1:0] num_packets;  // Frames per batch
      logic [13:0]           pkt_length;   // Whole frame, bytes
      logic [47:0]           mac_da;
      logic [47:0]           mac_sa;
      logic                  stop;         // Finish current frame, then idle
   } gen_cfg_t;

   // Sequencer states
   typedef enum logic [2:0] {
      seq_idle = 3'd0,
      seq_hdr0 = 3'd1,   // DA and top of SA
      seq_hdr1 = 3'd2,   // Rest of SA, length, sequence
      seq_data = 3'd3,   // Payload words
      seq_gap  = 3'd4    // One dead step between frames
   } seq_state_t;

   // One step from sequencer to word builder
   typedef struct packed {
      logic        valid;
      seq_state_t  kind;
      logic        first_data;  // First payload word of the frame
      logic        last;
      logic [2:0]  empty;       // Unused bytes in the last word
      logic [15:0] length;      // Clamped payload length
      logic [15:0] seq_num;
   } frame_step_t;

   // Two header layouts over the same 64-bit word
   typedef union packed {
      logic [`GEN_DATA_W-1:0] raw;
      struct packed {
         logic [47:0] da;
         logic [15:0] sa_hi;      // SA[47:32]
      } hdr0;
      struct packed {
         logic [31:0] sa_lo;      // SA[31:0]
         logic [15:0] len_field;
         logic [15:0] seq_num;
      } hdr1;
   } hdr_word_u;

   // Stream beat as driven on the tx port
   typedef struct packed {
      logic [`GEN_DATA_W-1:0] data;
      logic                   valid;
      logic                   sop;
      logic                   eop;
      logic [2:0]             empty;
   } beat_t;

endpackage

// File: csr/gen_csr.sv
`include "gen_params.svh"

module gen_csr (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`GEN_ADDR_W-1:0] address,
   input  logic                   write,
   input  logic                   read,
   input  logic [`GEN_CSR_W-1:0]  writedata,
   output logic [`GEN_CSR_W-1:0]  readdata,
   input  logic [31:0]            tx_count,   // Frames sent so far
   output gen_pkg::gen_cfg_t      cfg,
   output logic                   start       // One cycle launch pulse
);

   logic                  start_bit;  // Self clearing start flag
   logic                  start_d;    // Flag one cycle later, for the edge
   logic [`GEN_CSR_W-1:0] rd_mux;

   // ----------------------------------------
   // Write side
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cfg <= '0;
      end else if (write) begin
         case (address)
            `GEN_ADDR_NUMPKTS:   cfg.num_packets    <= writedata;
            `GEN_ADDR_STOP:      cfg.stop           <= writedata[0];
            `GEN_ADDR_MACSA0:    cfg.mac_sa[31:0]   <= writedata;
            `GEN_ADDR_MACSA1:    cfg.mac_sa[47:32]  <= writedata[15:0];  // Upper half only
            `GEN_ADDR_MACDA0:    cfg.mac_da[31:0]   <= writedata;
            `GEN_ADDR_MACDA1:    cfg.mac_da[47:32]  <= writedata[15:0];
            `GEN_ADDR_PKTLENGTH: cfg.pkt_length     <= writedata[13:0];
            default: ;                                  // Read only or unmapped
         endcase
      end
   end

   // Start flag drops by itself the cycle after it is set
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         start_bit <= 1'b0;
         start_d   <= 1'b0;
      end else begin
         start_d <= start_bit;
         if (write && address == `GEN_ADDR_START) begin
            start_bit <= writedata[0];
         end else if (start_bit) begin
            start_bit <= 1'b0;
         end
      end
   end

   assign start = start_bit & ~start_d;  // Rising edge only

   // ----------------------------------------
   // Read side
   // ----------------------------------------
   always_comb begin
      case (address)
         `GEN_ADDR_NUMPKTS:   rd_mux = cfg.num_packets;
         `GEN_ADDR_START:     rd_mux = `GEN_CSR_W'(start_bit);
         `GEN_ADDR_STOP:      rd_mux = `GEN_CSR_W'(cfg.stop);
         `GEN_ADDR_MACSA0:    rd_mux = cfg.mac_sa[31:0];
         `GEN_ADDR_MACSA1:    rd_mux = `GEN_CSR_W'(cfg.mac_sa[47:32]);
         `GEN_ADDR_MACDA0:    rd_mux = cfg.mac_da[31:0];
         `GEN_ADDR_MACDA1:    rd_mux = `GEN_CSR_W'(cfg.mac_da[47:32]);
         `GEN_ADDR_TXPKTCNT:  rd_mux = tx_count;
         `GEN_ADDR_PKTLENGTH: rd_mux = `GEN_CSR_W'(cfg.pkt_length);
         default:             rd_mux = '0;           // Unmapped reads as zero
      endcase
   end

   // Registered read data, held between reads
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (read) begin
         readdata <= rd_mux;
      end
   end

endmodule

// File: gen/frame_seq.sv
`include "gen_params.svh"

module frame_seq (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  gen_pkg::gen_cfg_t    cfg,
   input  logic                 tx_ready,   // Clock enable for the whole path
   output gen_pkg::frame_step_t step,
   output logic [31:0]          tx_count
);

   import gen_pkg::*;

   seq_state_t  state;
   seq_state_t  state_nx;
   logic [15:0] length;       // Clamped payload bytes of the current frame
   logic [15:0] len_clamped;
   logic [15:0] bytes_left;   // Payload bytes not yet stepped out
   logic [15:0] seq_num;
   logic [15:0] pkt_len_ext;
   logic        data_last;    // Final payload word
   logic        batch_done;

   // ----------------------------------------
   // Payload length from frame length
   // ----------------------------------------
   assign pkt_len_ext = 16'(cfg.pkt_length);

   always_comb begin
      if (pkt_len_ext < 16'(`GEN_HDR_BYTES)) begin
         len_clamped = '0;                                        // Headers only
      end else if (pkt_len_ext > 16'(`GEN_MAX_PAYLOAD + `GEN_HDR_BYTES)) begin
         len_clamped = 16'(`GEN_MAX_PAYLOAD);
      end else begin
         len_clamped = pkt_len_ext - 16'(`GEN_HDR_BYTES);
      end
   end

   assign data_last  = (bytes_left <= 16'd8);
   assign batch_done = cfg.stop | (tx_count == cfg.num_packets);

   // ----------------------------------------
   // State machine
   // ----------------------------------------
   always_comb begin
      state_nx = state;
      case (state)
         seq_idle: state_nx = seq_idle;                       // Left only by start
         seq_hdr0: state_nx = seq_hdr1;
         seq_hdr1: state_nx = (length == '0) ? seq_gap : seq_data;
         seq_data: if (data_last) state_nx = seq_gap;
         seq_gap:  state_nx = batch_done ? seq_idle : seq_hdr0;  // Continue or finish
         default:  state_nx = seq_idle;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= seq_idle;
      end else if (start) begin
         state <= seq_hdr0;          // Start wins even while stalled
      end else if (tx_ready) begin
         state <= state_nx;
      end
   end

   // Length latched while idle and on each gap, countdown through the payload
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         length     <= '0;
         bytes_left <= '0;
      end else begin
         if (state == seq_idle || (state == seq_gap && tx_ready)) begin
            length <= len_clamped;
         end
         if (tx_ready && state == seq_hdr1) begin
            bytes_left <= length;
         end else if (tx_ready && state == seq_data) begin
            bytes_left <= bytes_left - 16'd8;  // One 64-bit word
         end
      end
   end

   // Sequence number per frame, frame count per batch
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         seq_num  <= '0;
         tx_count <= '0;
      end else if (start) begin
         seq_num  <= '0;
         tx_count <= '0;
      end else if (tx_ready) begin
         if (state == seq_gap)  seq_num  <= seq_num + 16'd1;
         if (state == seq_hdr1) tx_count <= tx_count + 32'd1;  // Counted on header
      end
   end

   // ----------------------------------------
   // Step out to the word builder
   // ----------------------------------------
   always_comb begin
      step            = '0;
      step.valid      = (state == seq_hdr0) || (state == seq_hdr1) || (state == seq_data);
      step.kind       = state;
      step.first_data = (state == seq_data) && (bytes_left == length);
      step.length     = length;
      step.seq_num    = seq_num;
      if (state == seq_hdr1 && length == '0) begin
         step.last = 1'b1;                          // Empty payload ends on hdr1
      end else if (state == seq_data && data_last) begin
         step.last  = 1'b1;
         step.empty = 3'd0 - length[2:0];           // (8 - len mod 8) mod 8
      end
   end

endmodule

// File: gen/word_build.sv
`include "gen_params.svh"

module word_build (
   input  logic                 clk,
   input  logic                 reset,
   input  gen_pkg::gen_cfg_t    cfg,
   input  logic                 tx_ready,
   input  gen_pkg::frame_step_t step,
   output gen_pkg::beat_t       beat
);

   import gen_pkg::*;

   localparam logic [`GEN_DATA_W-1:0] PATTERN_STEP = `GEN_PATTERN_STEP;

   hdr_word_u              hdr;
   logic [`GEN_DATA_W-1:0] pattern_q;    // Last payload word sent
   logic [`GEN_DATA_W-1:0] pattern_nx;
   logic [`GEN_DATA_W-1:0] word_nx;
   logic [`GEN_DATA_W-1:0] data_q;
   logic                   valid_q;
   logic                   sop_q;
   logic                   eop_q;
   logic [2:0]             empty_q;

   // ----------------------------------------
   // Next payload word
   // ----------------------------------------
   always_comb begin
      if (step.first_data) begin
         pattern_nx = `GEN_PATTERN_INIT;   // Restart every frame
      end else begin
         // Per byte add, each lane wraps on its own
         for (int i = 0; i < `GEN_DATA_W / 8; i++) begin
            pattern_nx[8*i +: 8] = pattern_q[8*i +: 8] + PATTERN_STEP[8*i +: 8];
         end
      end
   end

   // Header word in one of its two layouts
   always_comb begin
      hdr.raw = '0;
      if (step.kind == seq_hdr0) begin
         hdr.hdr0.da    = cfg.mac_da;
         hdr.hdr0.sa_hi = cfg.mac_sa[47:32];
      end else begin
         hdr.hdr1.sa_lo     = cfg.mac_sa[31:0];
         hdr.hdr1.len_field = step.length + 16'(`GEN_LEN_FIELD_ADJ);
         hdr.hdr1.seq_num   = step.seq_num;
      end
   end

   assign word_nx = (step.kind == seq_data) ? pattern_nx : hdr.raw;

   // ----------------------------------------
   // Output registers
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         valid_q <= 1'b0;
         sop_q   <= 1'b0;
         eop_q   <= 1'b0;
         empty_q <= '0;
      end else if (tx_ready) begin     // Hold everything while stalled
         valid_q <= step.valid;
         sop_q   <= step.valid && step.kind == seq_hdr0;
         eop_q   <= step.last;
         empty_q <= step.empty;
      end
   end

   // Word and pattern state
   always_ff @(posedge clk) begin
      if (tx_ready && step.valid) begin
         data_q <= word_nx;
      end
      if (tx_ready && step.kind == seq_data) begin
         pattern_q <= pattern_nx;
      end
   end

   always_comb begin
      beat.data  = data_q;
      beat.valid = valid_q;
      beat.sop   = sop_q;
      beat.eop   = eop_q;
      beat.empty = empty_q;
   end

endmodule

// File: logic/avalon_st_gen.sv
`include "gen_params.svh"

module avalon_st_gen (
   input  logic                   clk,
   input  logic                   reset,
   // Register bus
   input  logic [`GEN_ADDR_W-1:0] address,
   input  logic                   write,
   input  logic                   read,
   input  logic [`GEN_CSR_W-1:0]  writedata,
   output logic [`GEN_CSR_W-1:0]  readdata,
   // Stream out
   input  logic                   tx_ready,
   output logic [`GEN_DATA_W-1:0] tx_data,
   output logic                   tx_valid,
   output logic                   tx_sop,
   output logic                   tx_eop,
   output logic [2:0]             tx_empty
);

   import gen_pkg::*;

   gen_cfg_t    cfg;
   logic        start;
   logic [31:0] tx_count;
   frame_step_t step;
   beat_t       beat;

   gen_csr u_csr (
      .clk       (clk),
      .reset     (reset),
      .address   (address),
      .write     (write),
      .read      (read),
      .writedata (writedata),
      .readdata  (readdata),
      .tx_count  (tx_count),
      .cfg       (cfg),
      .start     (start)
   );

   frame_seq u_seq (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .cfg      (cfg),
      .tx_ready (tx_ready),
      .step     (step),
      .tx_count (tx_count)
   );

   word_build u_build (
      .clk      (clk),
      .reset    (reset),
      .cfg      (cfg),
      .tx_ready (tx_ready),
      .step     (step),
      .beat     (beat)
   );

   // Beat onto the stream ports
   assign tx_data  = beat.data;
   assign tx_valid = beat.valid;
   assign tx_sop   = beat.sop;
   assign tx_eop   = beat.eop;
   assign tx_empty = beat.empty;

endmodule

// File: dv/tb_avalon_st_gen.sv
`include "gen_params.svh"

module tb_avalon_st_gen;

   timeunit 1ns;
   timeprecision 1ps;

   import gen_pkg::*;

   logic                   clk;
   logic                   reset;
   logic [`GEN_ADDR_W-1:0] address;
   logic                   write;
   logic                   read;
   logic [`GEN_CSR_W-1:0]  writedata;
   logic [`GEN_CSR_W-1:0]  readdata;
   logic                   tx_ready;
   logic [`GEN_DATA_W-1:0] tx_data;
   logic                   tx_valid;
   logic                   tx_sop;
   logic                   tx_eop;
   logic [2:0]             tx_empty;

   gen_cfg_t    shadow;         // MAC addresses as last written
   integer      seed;           // Back-pressure generator state
   int          limit_cycles;   // Watchdog budget from the trace
   byte         cmd_q[$];       // W, R or B per trace line
   logic [31:0] arg_a[$];
   logic [31:0] arg_b[$];
   logic [31:0] arg_c[$];
   logic [31:0] arg_d[$];

   avalon_st_gen u_avalon_st_gen (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   // ----------------------------------------
   // Reference frame model
   // ----------------------------------------
   function automatic logic [15:0] clamp_len(input logic [13:0] pkt);
      int p;
      p = int'(pkt);
      if (p < `GEN_HDR_BYTES) return 16'd0;                          // Headers only
      if (p > `GEN_MAX_PAYLOAD + `GEN_HDR_BYTES) return 16'(`GEN_MAX_PAYLOAD);
      return 16'(p - `GEN_HDR_BYTES);
   endfunction

   function automatic int data_words(input logic [15:0] len);
      return (int'(len) + 7) / 8;   // Partial last word counts
   endfunction

   // Expected beat idx of a frame with the two headers first
   function automatic beat_t model_beat(input logic [15:0] len, input logic [15:0] seq,
                                        input int idx);
      beat_t     b;
      hdr_word_u h;
      int        words;
      words   = data_words(len);
      b       = '0;
      b.valid = 1'b1;
      h.raw   = '0;
      if (idx == 0) begin
         h.hdr0.da    = shadow.mac_da;
         h.hdr0.sa_hi = shadow.mac_sa[47:32];
         b.data       = h.raw;
         b.sop        = 1'b1;
      end else if (idx == 1) begin
         h.hdr1.sa_lo     = shadow.mac_sa[31:0];
         h.hdr1.len_field = len + 16'(`GEN_LEN_FIELD_ADJ);
         h.hdr1.seq_num   = seq;
         b.data           = h.raw;
         b.eop            = (words == 0);   // Frame ends here without payload
      end else begin
         for (int j = 0; j < 8; j++) begin
            b.data[8*j +: 8] = 8'(7 - j + 8 * (idx - 2));   // Lane 0 holds byte 07
         end
         if (idx - 2 == words - 1) begin
            b.eop   = 1'b1;
            b.empty = 3'((8 - int'(len) % 8) % 8);
         end
      end
      return b;
   endfunction

   // ----------------------------------------
   // Checks
   // ----------------------------------------
   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1, "first error, run stopped");
   endtask

   task automatic report_mismatch(input string sig, input string where,
                                  input logic [63:0] got, input logic [63:0] exp);
      stop_with_error($sformatf("mismatch %s %s: got %0h expected %0h",
                                sig, where, got, exp));
   endtask

   // Beats are only compared while tx_valid is high
   task automatic compare_beat(input string what, input beat_t got, input beat_t exp);
      if (got.data !== exp.data)
         report_mismatch("tx_data", what, got.data, exp.data);
      if (got.sop !== exp.sop)
         report_mismatch("tx_sop", what, 64'(got.sop), 64'(exp.sop));
      if (got.eop !== exp.eop)
         report_mismatch("tx_eop", what, 64'(got.eop), 64'(exp.eop));
      if (got.empty !== exp.empty)
         report_mismatch("tx_empty", what, 64'(got.empty), 64'(exp.empty));
   endtask

   task automatic compare_csr(input string what, input logic [`GEN_CSR_W-1:0] got,
                              input logic [`GEN_CSR_W-1:0] exp);
      if (got !== exp)
         report_mismatch("readdata", what, 64'(got), 64'(exp));
   endtask

   // ----------------------------------------
   // Register bus
   // ----------------------------------------
   task automatic csr_write(input logic [`GEN_ADDR_W-1:0] addr, input logic [31:0] data);
      @(posedge clk);
      #1;
      address   = addr;
      writedata = data;
      write     = 1'b1;
      @(posedge clk);
      #1;
      write = 1'b0;
      case (addr)   // Track what the header words will carry
         `GEN_ADDR_MACSA0: shadow.mac_sa[31:0]  = data;
         `GEN_ADDR_MACSA1: shadow.mac_sa[47:32] = data[15:0];
         `GEN_ADDR_MACDA0: shadow.mac_da[31:0]  = data;
         `GEN_ADDR_MACDA1: shadow.mac_da[47:32] = data[15:0];
         default: ;
      endcase
   endtask

   task automatic csr_read_check(input logic [`GEN_ADDR_W-1:0] addr, input logic [31:0] exp);
      @(posedge clk);
      #1;
      address = addr;
      read    = 1'b1;
      @(posedge clk);
      #1;
      read = 1'b0;   // readdata registered on that edge
      compare_csr($sformatf("at address %h", addr), readdata, exp);
   endtask

   // ----------------------------------------
   // Frame batches
   // ----------------------------------------
   task automatic run_batch(input int pkt_len, input int count, input bit rnd, input int stop_at);
      logic [15:0] len;
      int          frames;
      int          per_frame;
      int          frame;
      int          idx;
      bit          stop_req;
      beat_t       got;
      len       = clamp_len(14'(pkt_len));
      frames    = (stop_at > 0) ? stop_at : count;   // Stop cuts the batch short
      per_frame = 2 + data_words(len);
      frame     = 0;
      idx       = 0;
      stop_req  = 1'b0;
      csr_write(`GEN_ADDR_PKTLENGTH, 32'(pkt_len));
      csr_write(`GEN_ADDR_NUMPKTS, 32'(count));
      csr_write(`GEN_ADDR_STOP, 32'd0);
      csr_write(`GEN_ADDR_START, 32'd1);
      while (frame < frames) begin
         @(posedge clk);
         #1;
         write    = stop_req;                 // Stop write lasts one cycle
         address  = `GEN_ADDR_STOP;
         writedata = 32'd1;
         stop_req = 1'b0;
         tx_ready = rnd ? (($random(seed) & 3) != 0) : 1'b1;
         @(negedge clk);
         if (tx_valid && tx_ready) begin       // Beat taken on the coming edge
            got = {tx_data, tx_valid, tx_sop, tx_eop, tx_empty};
            compare_beat($sformatf("in frame %0d word %0d", frame, idx), got,
                         model_beat(len, 16'(frame), idx));
            if (stop_at > 0 && frame == stop_at - 1 && idx == 0) stop_req = 1'b1;
            idx++;
            if (idx == per_frame) begin
               idx = 0;
               frame++;
            end
         end
      end
      // Nothing more may follow the last frame
      repeat (16) begin
         @(posedge clk);
         #1;
         write    = 1'b0;
         tx_ready = 1'b1;
         @(negedge clk);
         if (tx_valid) stop_with_error("a beat appeared after the batch should have ended");
      end
   endtask

   // ----------------------------------------
   // Trace file
   // ----------------------------------------
   task automatic load_trace();
      int          fd;
      int          n;
      int          beats;
      string       line;
      string       rest;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
      beats = 0;
      fd = $fopen("dv/gen_trace.txt", "r");
      if (fd == 0) stop_with_error("cannot open the trace file dv/gen_trace.txt");
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 1 && line[0] != "#") begin   // Skip blanks and comments
            rest = line.substr(1, line.len() - 1);
            c    = '0;
            d    = '0;
            if (line[0] == "B") begin
               n = $sscanf(rest, "%d %d %d %d", a, b, c, d);
               beats += int'((d != 0) ? d : b) * (2 + data_words(clamp_len(14'(a))));
            end else if (line[0] == "W" || line[0] == "R") begin
               n = 2 + $sscanf(rest, "%h %h", a, b);
            end else begin
               n = 0;
            end
            if (n != 4) stop_with_error($sformatf("badly formed trace line: %s", line));
            cmd_q.push_back(line[0]);
            arg_a.push_back(a);
            arg_b.push_back(b);
            arg_c.push_back(c);
            arg_d.push_back(d);
         end
      end
      $fclose(fd);
      limit_cycles = 20 * beats + 20 * cmd_q.size() + 100;   // Margin for register traffic
   endtask

   task automatic run_trace();
      for (int i = 0; i < cmd_q.size(); i++) begin
         case (cmd_q[i])
            "W":     csr_write(8'(arg_a[i]), arg_b[i]);
            "R":     csr_read_check(8'(arg_a[i]), arg_b[i]);
            default: run_batch(int'(arg_a[i]), int'(arg_b[i]), arg_c[i] != 0, int'(arg_d[i]));
         endcase
      end
   endtask

   // Watchdog
   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      stop_with_error("the stream stalled, watchdog limit reached");
   end

   initial begin
      seed         = 80;
      limit_cycles = 0;
      shadow       = '0;
      reset        = 1'b1;
      address      = '0;
      write        = 1'b0;
      read         = 1'b0;
      writedata    = '0;
      tx_ready     = 1'b1;
      load_trace();
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      run_trace();
      $display("NO ERRORS");
      $finish;
   end

endmodule

// File: dv/gen_trace.txt
# W addr data : register write, hex | R addr expected : register read, hex
# B pkt_length frames random_ready stop_after_frame : frame batch, decimal, 0 means no stop
W 05 a1b2c3d4
W 06 ffff0a0b
W 07 11223344
W 08 12345566
R 05 a1b2c3d4
R 06 00000a0b
R 07 11223344
R 08 00005566
R 0a 00000000
R 03 00000000
B 10 2 0 0
R 09 00000002
R 0d 0000000a
B 24 3 1 0
R 09 00000003
B 100 4 0 0
B 100 4 1 0
R 09 00000004
R 00 00000004
B 61 3 1 0
B 9700 2 1 0
R 0d 000025e4
B 300 6 1 2
R 09 00000002
R 04 00000001
B 9601 1 0 0
R 09 00000001

// File: all.f
+incdir+common
common/gen_pkg.sv
csr/gen_csr.sv
gen/frame_seq.sv
gen/word_build.sv
logic/avalon_st_gen.sv
dv/tb_avalon_st_gen.sv

// File: Makefile
TOOL      := verilator
FLAGS     := --timing --timescale 1ns/1ps
TOP       := tb_avalon_st_gen
FILE_LIST := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := NO ERRORS

.PHONY: sim lint clean

sim:
	$(TOOL) $(FLAGS) --binary --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) $(FLAGS) --lint-only --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)
